/* dv/uart_tb.sv */
`timescale 1ns/1ns

module uart_tb;

    localparam int DEFAULT_DIV = 4;
    localparam int HS_LIMIT    = 64;
    localparam int FRAME_DEF   = 10 * uart_pkg::OVERSAMPLE * DEFAULT_DIV;
    localparam int FRAME_MAX   = 10 * uart_pkg::OVERSAMPLE * 7;
    // 14 frames at the reset divisor, 2 at the largest test divisor, one full baud reload
    localparam int WATCHDOG_CLKS = 2 * (14 * FRAME_DEF + 2 * FRAME_MAX + 65536);
    localparam int TOGETHER   = 0;
    localparam int ADDR_FIRST = 1;
    localparam int DATA_FIRST = 2;

    logic            CLK, rstn;
    logic [31:0]     axi_araddr, axi_awaddr;
    logic            axi_arvalid, axi_arready, axi_rvalid, axi_rready;
    uart_pkg::data_t axi_rdata, axi_wdata;
    uart_pkg::strb_t axi_wstrb;
    logic            axi_awvalid, axi_awready, axi_wvalid, axi_wready;
    logic            axi_bvalid, axi_bready;
    logic            tx, rx, rx_drv, loopback;
    logic            bvalid_prev = 1'b0;
    int              value_errors, proto_errors, bvalid_rises, cur_div;
    logic [31:0]     lfsr_state;
    string           test_name;

    uart_tb_clk clk0 (.CLK, .rstn);

    // Serial input comes from the driver or straight back from tx
    assign rx = loopback ? tx : rx_drv;

    uart_top #(
        .ADDR_WIDTH  (32),
        .DEFAULT_DIV (DEFAULT_DIV)
    ) dut0 (
        .CLK, .rstn,
        .axi_araddr, .axi_arvalid, .axi_arready,
        .axi_rdata, .axi_rvalid, .axi_rready,
        .axi_awaddr, .axi_awvalid, .axi_awready,
        .axi_wdata, .axi_wstrb, .axi_wvalid, .axi_wready,
        .axi_bvalid, .axi_bready,
        .tx, .rx
    );

    always @(posedge CLK) begin
        if (axi_bvalid && !bvalid_prev) bvalid_rises++;
        bvalid_prev = axi_bvalid;
    end

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h8020_0003 : lfsr_state >> 1;
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic uart_pkg::data_t expected_status(input logic busy, valid, ovr, ferr);
        uart_pkg::data_t w;
        w = '0;
        w[uart_pkg::STAT_TX_BUSY]   = busy;
        w[uart_pkg::STAT_RX_VALID]  = valid;
        w[uart_pkg::STAT_OVERRUN]   = ovr;
        w[uart_pkg::STAT_FRAME_ERR] = ferr;
        return w;
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge CLK);
    endtask

    task automatic protocol_error(input string msg);
        proto_errors++;
        $display("ERROR %s: %s", test_name, msg);
    endtask

    task automatic compare_data(input string what, input uart_pkg::data_t exp,
                                input uart_pkg::data_t act);
        if (act !== exp) begin
            value_errors++;
            $display("FAIL %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic compare_byte(input string what, input uart_pkg::byte_t exp,
                                input uart_pkg::byte_t act);
        if (act !== exp) begin
            value_errors++;
            $display("FAIL %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic compare_div(input string what, input uart_pkg::div_t exp,
                               input uart_pkg::div_t act);
        if (act !== exp) begin
            value_errors++;
            $display("FAIL %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic axil_write(input logic [3:0] addr, input uart_pkg::data_t data,
                              input uart_pkg::strb_t strb, input int mode);
        logic aw_done, w_done, aw_hs, w_hs;
        int n, hold;
        aw_done = 1'b0;
        w_done  = 1'b0;
        n       = 0;
        if (mode != DATA_FIRST) begin
            axi_awaddr  <= 32'(addr);
            axi_awvalid <= 1'b1;
        end
        if (mode != ADDR_FIRST) begin
            axi_wdata  <= data;
            axi_wstrb  <= strb;
            axi_wvalid <= 1'b1;
        end
        while (!(aw_done && w_done) && n < HS_LIMIT) begin
            @(posedge CLK);
            n++;
            aw_hs = axi_awvalid && axi_awready;
            w_hs  = axi_wvalid && axi_wready;
            if (aw_hs) aw_done = 1'b1;
            if (w_hs) w_done = 1'b1;
            if (aw_hs) axi_awvalid <= 1'b0;
            if (w_hs) axi_wvalid <= 1'b0;
            // Second channel follows the first
            if (aw_hs && !w_done) begin
                axi_wdata  <= data;
                axi_wstrb  <= strb;
                axi_wvalid <= 1'b1;
            end
            if (w_hs && !aw_done) begin
                axi_awaddr  <= 32'(addr);
                axi_awvalid <= 1'b1;
            end
        end
        if (!(aw_done && w_done)) begin
            protocol_error("write address or data handshake timed out");
            axi_awvalid <= 1'b0;
            axi_wvalid  <= 1'b0;
            return;
        end
        n = 0;
        while (axi_bvalid !== 1'b1 && n < HS_LIMIT) begin
            @(posedge CLK);
            n++;
        end
        if (axi_bvalid !== 1'b1) begin
            protocol_error("write response never became valid");
            return;
        end
        if (n - 1 != 1) protocol_error($sformatf("bvalid rose %0d cycles late, expected 1", n - 1));
        hold = int'(rand_bits(3));
        repeat (hold) begin
            @(posedge CLK);
            if (axi_bvalid !== 1'b1) protocol_error("bvalid dropped while bready was low");
        end
        axi_bready <= 1'b1;
        @(posedge CLK);
        axi_bready <= 1'b0;
        @(posedge CLK);
        if (axi_bvalid !== 1'b0) protocol_error("bvalid stayed high after the response handshake");
    endtask

    task automatic axil_read(input logic [3:0] addr, output uart_pkg::data_t data);
        uart_pkg::data_t first;
        logic done;
        int n, hold;
        data = '0;
        done = 1'b0;
        n    = 0;
        axi_araddr  <= 32'(addr);
        axi_arvalid <= 1'b1;
        while (!done && n < HS_LIMIT) begin
            @(posedge CLK);
            n++;
            if (axi_arvalid && axi_arready) begin
                done = 1'b1;
                axi_arvalid <= 1'b0;
            end
        end
        if (!done) begin
            protocol_error("read address handshake timed out");
            axi_arvalid <= 1'b0;
            return;
        end
        n = 0;
        while (axi_rvalid !== 1'b1 && n < HS_LIMIT) begin
            @(posedge CLK);
            n++;
        end
        if (axi_rvalid !== 1'b1) begin
            protocol_error("read data never became valid");
            return;
        end
        if (n - 1 != 2) protocol_error($sformatf("rvalid rose %0d cycles late, expected 2", n - 1));
        first = axi_rdata;
        hold  = int'(rand_bits(3));
        repeat (hold) begin
            @(posedge CLK);
            if (axi_rvalid !== 1'b1 || axi_rdata !== first)
                protocol_error("read data dropped or changed while rready was low");
        end
        axi_rready <= 1'b1;
        @(posedge CLK);
        data = axi_rdata;
        axi_rready <= 1'b0;
    endtask

    task automatic uart_send_frame(input uart_pkg::byte_t b, input logic stop_bit);
        int bit_clks, i;
        bit_clks = uart_pkg::OVERSAMPLE * cur_div;
        rx_drv <= 1'b0;
        wait_cycles(bit_clks);
        for (i = 0; i < 8; i++) begin
            rx_drv <= b[i];
            wait_cycles(bit_clks);
        end
        rx_drv <= stop_bit;
        wait_cycles(bit_clks);
        // One idle bit lets the receiver settle
        rx_drv <= 1'b1;
        wait_cycles(bit_clks);
    endtask

    task automatic uart_recv_frame(output uart_pkg::byte_t b, output logic ok);
        int bit_clks, n, i;
        bit_clks = uart_pkg::OVERSAMPLE * cur_div;
        ok = 1'b0;
        b  = '0;
        n  = 0;
        while (tx !== 1'b0 && n < 4 * bit_clks) begin
            @(posedge CLK);
            n++;
        end
        if (tx !== 1'b0) begin
            protocol_error("no start bit appeared on tx");
            return;
        end
        wait_cycles(bit_clks / 2);
        if (tx !== 1'b0) begin
            protocol_error("start bit on tx ended before its centre");
            return;
        end
        // Sample each bit at its centre, LSB first
        for (i = 0; i < 8; i++) begin
            wait_cycles(bit_clks);
            b[i] = tx;
        end
        wait_cycles(bit_clks);
        if (tx !== 1'b1) begin
            protocol_error("stop bit on tx was low");
            return;
        end
        ok = 1'b1;
        wait_cycles(bit_clks / 2 + cur_div);
    endtask

    task automatic test_reset();
        uart_pkg::data_t rd;
        test_name = "reset";
        while (rstn) @(posedge CLK);
        if ({axi_arready, axi_awready, axi_wready, axi_rvalid, axi_bvalid, tx} !== 6'b000001)
            protocol_error("bus outputs not low or tx not high in reset");
        @(posedge CLK);
        if ({axi_arready, axi_awready, axi_wready} !== 3'b111)
            protocol_error("ready outputs did not rise on the first clock after reset");
        axil_read(uart_pkg::REG_STATUS, rd);
        compare_data("STATUS", expected_status(0, 0, 0, 0), rd);
        axil_read(uart_pkg::REG_DIVISOR, rd);
        compare_data("DIVISOR", uart_pkg::data_t'(DEFAULT_DIV), rd);
        // Read-only offsets take the write and keep their value
        axil_write(uart_pkg::REG_STATUS, 32'hffff_ffff, 4'hf, TOGETHER);
        axil_write(uart_pkg::REG_RXDATA, 32'hffff_ffff, 4'hf, DATA_FIRST);
        axil_read(uart_pkg::REG_STATUS, rd);
        compare_data("STATUS after write", expected_status(0, 0, 0, 0), rd);
        axil_read(uart_pkg::REG_DIVISOR, rd);
        compare_data("DIVISOR after writes", uart_pkg::data_t'(DEFAULT_DIV), rd);
        if (tx !== 1'b1) protocol_error("tx left the idle level");
    endtask

    task automatic test_write_order();
        uart_pkg::byte_t b, got;
        logic ok;
        int modes[3];
        int rises, i;
        test_name = "write_order";
        modes = '{ADDR_FIRST, DATA_FIRST, TOGETHER};
        rises = bvalid_rises;
        for (i = 0; i < 3; i++) begin
            b = uart_pkg::byte_t'(rand_bits(8));
            fork
                axil_write(uart_pkg::REG_TXDATA, {24'h0, b}, 4'h1, modes[i]);
                uart_recv_frame(got, ok);
            join
            if (ok) compare_byte("tx frame", b, got);
        end
        if (bvalid_rises - rises != 3)
            protocol_error($sformatf("%0d write responses for 3 writes", bvalid_rises - rises));
    endtask

    task automatic test_receive();
        uart_pkg::data_t rd;
        uart_pkg::byte_t b, got;
        logic ok;
        int i;
        test_name = "receive";
        for (i = 0; i < 3; i++) begin
            b = uart_pkg::byte_t'(rand_bits(8));
            uart_send_frame(b, 1'b1);
            axil_read(uart_pkg::REG_STATUS, rd);
            compare_data("STATUS after frame", expected_status(0, 1, 0, 0), rd);
            axil_read(uart_pkg::REG_RXDATA, rd);
            compare_data("RXDATA", {24'h0, b}, rd);
            axil_read(uart_pkg::REG_STATUS, rd);
            compare_data("STATUS after RXDATA read", expected_status(0, 0, 0, 0), rd);
        end
        test_name = "loopback";
        loopback <= 1'b1;
        b = uart_pkg::byte_t'(rand_bits(8));
        fork
            axil_write(uart_pkg::REG_TXDATA, {24'h0, b}, 4'h1, TOGETHER);
            uart_recv_frame(got, ok);
        join
        if (ok) compare_byte("tx frame", b, got);
        wait_cycles(uart_pkg::OVERSAMPLE * cur_div);
        axil_read(uart_pkg::REG_STATUS, rd);
        compare_data("STATUS after frame", expected_status(0, 1, 0, 0), rd);
        axil_read(uart_pkg::REG_RXDATA, rd);
        compare_data("RXDATA", {24'h0, b}, rd);
        loopback <= 1'b0;
    endtask

    task automatic test_error_flags();
        uart_pkg::data_t rd;
        uart_pkg::byte_t b0, b1;
        test_name = "error_flags";
        b0 = uart_pkg::byte_t'(rand_bits(8));
        b1 = uart_pkg::byte_t'(rand_bits(8));
        uart_send_frame(b0, 1'b1);
        uart_send_frame(b1, 1'b1);
        axil_read(uart_pkg::REG_STATUS, rd);
        compare_data("STATUS after overrun", expected_status(0, 1, 1, 0), rd);
        axil_read(uart_pkg::REG_STATUS, rd);
        compare_data("STATUS after clear", expected_status(0, 1, 0, 0), rd);
        // Low stop bit, byte is dropped
        uart_send_frame(uart_pkg::byte_t'(rand_bits(8)), 1'b0);
        axil_read(uart_pkg::REG_STATUS, rd);
        compare_data("STATUS after bad stop", expected_status(0, 1, 0, 1), rd);
        axil_read(uart_pkg::REG_STATUS, rd);
        compare_data("STATUS after clear", expected_status(0, 1, 0, 0), rd);
        axil_read(uart_pkg::REG_RXDATA, rd);
        compare_data("RXDATA keeps first byte", {24'h0, b0}, rd);
        axil_read(uart_pkg::REG_STATUS, rd);
        compare_data("STATUS at end", expected_status(0, 0, 0, 0), rd);
    endtask

    task automatic test_divisor();
        uart_pkg::data_t rd, wdata;
        uart_pkg::strb_t strb;
        uart_pkg::div_t  exp_div, new_div;
        uart_pkg::byte_t b, got;
        logic ok;
        int n;
        test_name = "divisor";
        wdata   = rand_bits(32);
        strb    = uart_pkg::strb_t'(rand_bits(4));
        exp_div = uart_pkg::div_t'(cur_div);
        if (strb[0]) exp_div[7:0] = wdata[7:0];
        if (strb[1]) exp_div[15:8] = wdata[15:8];
        axil_write(uart_pkg::REG_DIVISOR, wdata, strb, TOGETHER);
        axil_read(uart_pkg::REG_DIVISOR, rd);
        compare_div("DIVISOR after strobed write", exp_div, rd[15:0]);
        new_div = uart_pkg::div_t'(3 + rand_bits(2));
        axil_write(uart_pkg::REG_DIVISOR, {16'h0, new_div}, 4'h3, TOGETHER);
        axil_read(uart_pkg::REG_DIVISOR, rd);
        compare_div("DIVISOR after full write", new_div, rd[15:0]);
        // Baud counter may still run down a reload of the previous value
        wait_cycles(int'(exp_div) + 2);
        cur_div = int'(new_div);
        b = uart_pkg::byte_t'(rand_bits(8));
        fork
            begin
                axil_write(uart_pkg::REG_TXDATA, {24'h0, b}, 4'h1, TOGETHER);
                axil_read(uart_pkg::REG_STATUS, rd);
                compare_data("STATUS while sending", expected_status(1, 0, 0, 0), rd);
                axil_write(uart_pkg::REG_TXDATA, {24'h0, ~b}, 4'h1, ADDR_FIRST);
            end
            uart_recv_frame(got, ok);
        join
        if (ok) compare_byte("tx frame at new divisor", b, got);
        n = 0;
        repeat (3 * uart_pkg::OVERSAMPLE * cur_div) begin
            @(posedge CLK);
            if (tx !== 1'b1) n++;
        end
        if (n != 0) protocol_error("tx sent a second frame for a write made while busy");
    endtask

    initial begin
        axi_araddr  = '0;
        axi_arvalid = 1'b0;
        axi_rready  = 1'b0;
        axi_awaddr  = '0;
        axi_awvalid = 1'b0;
        axi_wdata   = '0;
        axi_wstrb   = '0;
        axi_wvalid  = 1'b0;
        axi_bready  = 1'b0;
        rx_drv      = 1'b1;
        loopback    = 1'b0;
        cur_div     = DEFAULT_DIV;
        lfsr_state  = 32'hd774_5294;
        @(posedge CLK);
        test_reset();
        test_write_order();
        test_receive();
        test_error_flags();
        test_divisor();
        wait_cycles(4);
        $display("Errors: %0d value mismatches, %0d protocol errors", value_errors, proto_errors);
        if (value_errors == 0 && proto_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CLKS) @(posedge CLK);
        $display("Watchdog expired after %0d clock cycles, tests did not finish", WATCHDOG_CLKS);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

/* dv/uart_tb_clk.sv */
`timescale 1ns/1ns

module uart_tb_clk #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 3
) (
    output logic CLK,
    output logic rstn
);

    initial begin
        CLK  = 1'b0;
        rstn = 1'b1;
    end

    always #(PERIOD / 2) CLK = ~CLK;

    // Reset is active high, released after a fixed count of edges
    initial begin
        repeat (RESET_CYCLES) @(posedge CLK);
        rstn <= 1'b0;
    end

endmodule

/* hdl/uart_axil_regs.sv */
`timescale 1ns/1ns

module uart_axil_regs #(
    parameter int ADDR_WIDTH  = 32,
    parameter int DEFAULT_DIV = 4
) (
    input  logic                  CLK,
    input  logic                  rstn,
    input  logic [ADDR_WIDTH-1:0] axi_araddr,
    input  logic                  axi_arvalid,
    output logic                  axi_arready,
    output uart_pkg::data_t       axi_rdata,
    output logic                  axi_rvalid,
    input  logic                  axi_rready,
    input  logic [ADDR_WIDTH-1:0] axi_awaddr,
    input  logic                  axi_awvalid,
    output logic                  axi_awready,
    input  uart_pkg::data_t       axi_wdata,
    input  uart_pkg::strb_t       axi_wstrb,
    input  logic                  axi_wvalid,
    output logic                  axi_wready,
    output logic                  axi_bvalid,
    input  logic                  axi_bready,
    input  logic                  tx_busy,
    input  logic                  rx_done,
    input  uart_pkg::byte_t       rx_byte,
    input  logic                  rx_frame_err,
    output logic                  tx_load,
    output uart_pkg::byte_t       tx_byte,
    output uart_pkg::div_t        div
);

    localparam logic [1:0] SEL_TXDATA  = uart_pkg::REG_TXDATA[3:2];
    localparam logic [1:0] SEL_RXDATA  = uart_pkg::REG_RXDATA[3:2];
    localparam logic [1:0] SEL_STATUS  = uart_pkg::REG_STATUS[3:2];
    localparam logic [1:0] SEL_DIVISOR = uart_pkg::REG_DIVISOR[3:2];

    uart_pkg::rd_state_e rd_state;
    uart_pkg::wr_state_e wr_state;

    logic            ar_hs, aw_hs, w_hs;
    logic [1:0]      rd_sel, wr_sel;
    uart_pkg::data_t wdata_q;
    uart_pkg::strb_t wstrb_q;
    uart_pkg::data_t rd_word, status_word;
    logic            wr_commit, clr_rx, clr_stat;
    logic            rx_valid, overrun, frame_err;
    uart_pkg::byte_t rx_hold;

    assign ar_hs = axi_arvalid && axi_arready;
    assign aw_hs = axi_awvalid && axi_awready;
    assign w_hs  = axi_wvalid && axi_wready;

    // Register write happens on the edge where bvalid rises
    assign wr_commit = (wr_state == uart_pkg::WR_RESP) && !axi_bvalid;
    assign tx_load   = wr_commit && (wr_sel == SEL_TXDATA) && wstrb_q[0];
    assign tx_byte   = wdata_q[7:0];

    assign clr_rx   = (rd_state == uart_pkg::RD_DATA) && (rd_sel == SEL_RXDATA);
    assign clr_stat = (rd_state == uart_pkg::RD_DATA) && (rd_sel == SEL_STATUS);

    always_ff @(posedge CLK) begin
        if (ar_hs) rd_sel <= axi_araddr[3:2];
        if (aw_hs) wr_sel <= axi_awaddr[3:2];
        if (w_hs) begin
            wdata_q <= axi_wdata;
            wstrb_q <= axi_wstrb;
        end
        if (rd_state == uart_pkg::RD_DATA) axi_rdata <= rd_word;
        if (rx_done && (!rx_valid || clr_rx)) rx_hold <= rx_byte;
    end

    always_comb begin
        status_word = '0;
        status_word[uart_pkg::STAT_TX_BUSY]   = tx_busy;
        status_word[uart_pkg::STAT_RX_VALID]  = rx_valid;
        status_word[uart_pkg::STAT_OVERRUN]   = overrun;
        status_word[uart_pkg::STAT_FRAME_ERR] = frame_err;
    end

    always_comb begin
        case (rd_sel)
            SEL_RXDATA:  rd_word = {24'b0, rx_hold};
            SEL_STATUS:  rd_word = status_word;
            SEL_DIVISOR: rd_word = {16'b0, div};
            default:     rd_word = '0;
        endcase
    end

    // Read side: address, register sample, then data valid
    always_ff @(posedge CLK) begin
        if (rstn) begin
            rd_state    <= uart_pkg::RD_IDLE;
            axi_arready <= 1'b0;
            axi_rvalid  <= 1'b0;
        end else begin
            case (rd_state)
                uart_pkg::RD_IDLE: begin
                    axi_arready <= 1'b1;
                    if (ar_hs) begin
                        axi_arready <= 1'b0;
                        rd_state    <= uart_pkg::RD_DATA;
                    end
                end
                uart_pkg::RD_DATA: rd_state <= uart_pkg::RD_WAIT;
                uart_pkg::RD_WAIT: begin
                    if (!axi_rvalid) begin
                        axi_rvalid <= 1'b1;
                    end else if (axi_rready) begin
                        axi_rvalid <= 1'b0;
                        rd_state   <= uart_pkg::RD_IDLE;
                    end
                end
                default: rd_state <= uart_pkg::RD_IDLE;
            endcase
        end
    end

    // Write side takes address and data in either order
    always_ff @(posedge CLK) begin
        if (rstn) begin
            wr_state    <= uart_pkg::WR_IDLE;
            axi_awready <= 1'b0;
            axi_wready  <= 1'b0;
            axi_bvalid  <= 1'b0;
            div         <= uart_pkg::div_t'(DEFAULT_DIV);
        end else begin
            case (wr_state)
                uart_pkg::WR_IDLE: begin
                    axi_awready <= 1'b1;
                    axi_wready  <= 1'b1;
                    if (aw_hs && w_hs) begin
                        axi_awready <= 1'b0;
                        axi_wready  <= 1'b0;
                        wr_state    <= uart_pkg::WR_RESP;
                    end else if (aw_hs) begin
                        axi_awready <= 1'b0;
                        wr_state    <= uart_pkg::WR_WAIT_DATA;
                    end else if (w_hs) begin
                        axi_wready <= 1'b0;
                        wr_state   <= uart_pkg::WR_WAIT_ADDR;
                    end
                end
                uart_pkg::WR_WAIT_DATA: begin
                    if (w_hs) begin
                        axi_wready <= 1'b0;
                        wr_state   <= uart_pkg::WR_RESP;
                    end
                end
                uart_pkg::WR_WAIT_ADDR: begin
                    if (aw_hs) begin
                        axi_awready <= 1'b0;
                        wr_state    <= uart_pkg::WR_RESP;
                    end
                end
                uart_pkg::WR_RESP: begin
                    if (!axi_bvalid) begin
                        axi_bvalid <= 1'b1;
                    end else if (axi_bready) begin
                        axi_bvalid <= 1'b0;
                        wr_state   <= uart_pkg::WR_IDLE;
                    end
                end
                default: wr_state <= uart_pkg::WR_IDLE;
            endcase
            if (wr_commit && (wr_sel == SEL_DIVISOR)) begin
                if (wstrb_q[0]) div[7:0]  <= wdata_q[7:0];
                if (wstrb_q[1]) div[15:8] <= wdata_q[15:8];
            end
        end
    end

    // Receive flags, a new event wins over a clear on the same edge
    always_ff @(posedge CLK) begin
        if (rstn) begin
            rx_valid  <= 1'b0;
            overrun   <= 1'b0;
            frame_err <= 1'b0;
        end else begin
            if (clr_rx) rx_valid <= 1'b0;
            if (clr_stat) begin
                overrun   <= 1'b0;
                frame_err <= 1'b0;
            end
            if (rx_done) begin
                if (rx_valid && !clr_rx) overrun <= 1'b1;
                else rx_valid <= 1'b1;
            end
            if (rx_frame_err) frame_err <= 1'b1;
        end
    end

endmodule

/* hdl/uart_baud_gen.sv */
`timescale 1ns/1ns

module uart_baud_gen (
    input  logic           CLK,
    input  logic           rstn,
    input  uart_pkg::div_t div,
    output logic           tick
);

    uart_pkg::div_t cnt;
    uart_pkg::div_t div_eff;

    // A zero divisor runs as one tick per clock
    assign div_eff = (div == '0) ? uart_pkg::div_t'(1) : div;

    always_ff @(posedge CLK) begin
        if (rstn) begin
            cnt  <= '0;
            tick <= 1'b0;
        end else if (cnt <= uart_pkg::div_t'(1)) begin
            // New divisor is picked up only here
            cnt  <= div_eff;
            tick <= 1'b1;
        end else begin
            cnt  <= cnt - uart_pkg::div_t'(1);
            tick <= 1'b0;
        end
    end

endmodule

/* hdl/uart_pkg.sv */
package uart_pkg;

    // Widths with a meaning on the bus and the serial side
    typedef logic [31:0] data_t;
    typedef logic [7:0]  byte_t;
    typedef logic [15:0] div_t;
    typedef logic [3:0]  strb_t;

    // Baud ticks per serial bit
    localparam int OVERSAMPLE = 16;

    // Register byte offsets, only bits 3:2 are decoded
    localparam logic [3:0] REG_TXDATA  = 4'h0;
    localparam logic [3:0] REG_RXDATA  = 4'h4;
    localparam logic [3:0] REG_STATUS  = 4'h8;
    localparam logic [3:0] REG_DIVISOR = 4'hc;

    // Status word bit positions
    localparam int STAT_TX_BUSY   = 0;
    localparam int STAT_RX_VALID  = 1;
    localparam int STAT_OVERRUN   = 2;
    localparam int STAT_FRAME_ERR = 3;

    typedef enum logic [1:0] {RD_IDLE, RD_DATA, RD_WAIT} rd_state_e;
    typedef enum logic [1:0] {WR_IDLE, WR_WAIT_DATA, WR_WAIT_ADDR, WR_RESP} wr_state_e;
    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;
    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

endpackage

/* hdl/uart_rx.sv */
`timescale 1ns/1ns

module uart_rx (
    input  logic            CLK,
    input  logic            rstn,
    input  logic            tick,
    input  logic            rx,
    output logic            rx_done,
    output uart_pkg::byte_t rx_byte,
    output logic            rx_frame_err
);

    localparam int CNT_W = $clog2(uart_pkg::OVERSAMPLE);
    localparam logic [CNT_W-1:0] LAST_TICK = CNT_W'(uart_pkg::OVERSAMPLE - 1);
    localparam logic [CNT_W-1:0] MID_TICK  = CNT_W'(uart_pkg::OVERSAMPLE / 2 - 1);

    uart_pkg::rx_state_e state;
    logic                rx_meta, rx_sync;
    logic [CNT_W-1:0]    tick_cnt;
    logic [2:0]          bit_idx;
    uart_pkg::byte_t     shreg;

    assign rx_byte = shreg;

    // Two-flop synchronizer, line idles high
    always_ff @(posedge CLK) begin
        if (rstn) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge CLK) begin
        if (rstn) begin
            state        <= uart_pkg::RX_IDLE;
            tick_cnt     <= '0;
            bit_idx      <= '0;
            rx_done      <= 1'b0;
            rx_frame_err <= 1'b0;
        end else begin
            rx_done      <= 1'b0;
            rx_frame_err <= 1'b0;
            if (tick) begin
                case (state)
                    uart_pkg::RX_IDLE: begin
                        if (!rx_sync) begin
                            tick_cnt <= '0;
                            state    <= uart_pkg::RX_START;
                        end
                    end
                    uart_pkg::RX_START: begin
                        if (tick_cnt == MID_TICK) begin
                            // Still low at mid-bit, else a glitch
                            tick_cnt <= '0;
                            bit_idx  <= '0;
                            state    <= rx_sync ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA;
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                    uart_pkg::RX_DATA: begin
                        if (tick_cnt == LAST_TICK) begin
                            tick_cnt <= '0;
                            shreg    <= {rx_sync, shreg[7:1]};
                            if (bit_idx == 3'd7) state <= uart_pkg::RX_STOP;
                            else bit_idx <= bit_idx + 1'b1;
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                    uart_pkg::RX_STOP: begin
                        if (tick_cnt == LAST_TICK) begin
                            // Stop bit checked at its centre
                            tick_cnt     <= '0;
                            rx_done      <= rx_sync;
                            rx_frame_err <= !rx_sync;
                            state        <= uart_pkg::RX_IDLE;
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                    default: state <= uart_pkg::RX_IDLE;
                endcase
            end
        end
    end

endmodule

/* hdl/uart_top.sv */
`timescale 1ns/1ns

module uart_top #(
    parameter int ADDR_WIDTH  = 32,
    parameter int DEFAULT_DIV = 4
) (
    input  logic                  CLK,
    input  logic                  rstn,
    input  logic [ADDR_WIDTH-1:0] axi_araddr,
    input  logic                  axi_arvalid,
    output logic                  axi_arready,
    output uart_pkg::data_t       axi_rdata,
    output logic                  axi_rvalid,
    input  logic                  axi_rready,
    input  logic [ADDR_WIDTH-1:0] axi_awaddr,
    input  logic                  axi_awvalid,
    output logic                  axi_awready,
    input  uart_pkg::data_t       axi_wdata,
    input  uart_pkg::strb_t       axi_wstrb,
    input  logic                  axi_wvalid,
    output logic                  axi_wready,
    output logic                  axi_bvalid,
    input  logic                  axi_bready,
    output logic                  tx,
    input  logic                  rx
);

    logic            tx_load, tx_busy, tick;
    logic            rx_done, rx_frame_err;
    uart_pkg::byte_t tx_byte, rx_byte;
    uart_pkg::div_t  div;

    // Bus side register block
    uart_axil_regs #(
        .ADDR_WIDTH  (ADDR_WIDTH),
        .DEFAULT_DIV (DEFAULT_DIV)
    ) regs0 (
        .CLK, .rstn,
        .axi_araddr, .axi_arvalid, .axi_arready,
        .axi_rdata, .axi_rvalid, .axi_rready,
        .axi_awaddr, .axi_awvalid, .axi_awready,
        .axi_wdata, .axi_wstrb, .axi_wvalid, .axi_wready,
        .axi_bvalid, .axi_bready,
        .tx_busy, .rx_done, .rx_byte, .rx_frame_err,
        .tx_load, .tx_byte, .div
    );

    uart_baud_gen baud0 (
        .CLK, .rstn, .div, .tick
    );

    // Serial side shares one oversample tick
    uart_tx tx0 (
        .CLK, .rstn, .tick, .tx_load, .tx_byte, .tx, .tx_busy
    );

    uart_rx rx0 (
        .CLK, .rstn, .tick, .rx, .rx_done, .rx_byte, .rx_frame_err
    );

endmodule

/* hdl/uart_tx.sv */
`timescale 1ns/1ns

module uart_tx (
    input  logic            CLK,
    input  logic            rstn,
    input  logic            tick,
    input  logic            tx_load,
    input  uart_pkg::byte_t tx_byte,
    output logic            tx,
    output logic            tx_busy
);

    localparam int CNT_W = $clog2(uart_pkg::OVERSAMPLE);
    localparam logic [CNT_W-1:0] LAST_TICK = CNT_W'(uart_pkg::OVERSAMPLE - 1);

    uart_pkg::tx_state_e state;
    logic [CNT_W-1:0]    tick_cnt;
    logic [2:0]          bit_idx;
    uart_pkg::byte_t     shreg;
    logic                bit_end;

    assign bit_end = tick && (tick_cnt == LAST_TICK);
    assign tx_busy = (state != uart_pkg::TX_IDLE);

    always_ff @(posedge CLK) begin
        if (rstn) begin
            state    <= uart_pkg::TX_IDLE;
            tx       <= 1'b1;
            tick_cnt <= '0;
            bit_idx  <= '0;
        end else begin
            if (state != uart_pkg::TX_IDLE && tick) begin
                tick_cnt <= bit_end ? '0 : tick_cnt + 1'b1;
            end
            case (state)
                uart_pkg::TX_IDLE: begin
                    tx <= 1'b1;
                    if (tx_load) begin
                        shreg    <= tx_byte;
                        tick_cnt <= '0;
                        tx       <= 1'b0;
                        state    <= uart_pkg::TX_START;
                    end
                end
                uart_pkg::TX_START: begin
                    if (bit_end) begin
                        tx      <= shreg[0];
                        bit_idx <= '0;
                        state   <= uart_pkg::TX_DATA;
                    end
                end
                uart_pkg::TX_DATA: begin
                    if (bit_end) begin
                        if (bit_idx == 3'd7) begin
                            tx    <= 1'b1;
                            state <= uart_pkg::TX_STOP;
                        end else begin
                            // LSB first
                            shreg   <= {1'b0, shreg[7:1]};
                            tx      <= shreg[1];
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end
                end
                uart_pkg::TX_STOP: begin
                    if (bit_end) state <= uart_pkg::TX_IDLE;
                end
                default: state <= uart_pkg::TX_IDLE;
            endcase
        end
    end

endmodule

/* list.f */
hdl/uart_pkg.sv
hdl/uart_baud_gen.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/uart_axil_regs.sv
hdl/uart_top.sv
dv/uart_tb_clk.sv
dv/uart_tb.sv
